// File: verif/shim_cases.txt
// cfg_mask spi_mode boot_vec run_mask run_vec exp_code exp_board
// cfg_mask 8 thresh avg, 4 window, 2 integ en, 1 sys en; spi_mode 0 normal, 1 never off, 2 never starts
// run_mask 01 en drop, 02 lock, 04 sense, 08 ext, 10 over, 20 bad cmd, 40 underflow, 80 overflow
// run_vec 00 draws a random vector; exp_board 8 is the lowest flag of the vector in use
8 0 00 00 00 200 0
F 0 00 00 00 200 0
7 0 00 00 00 201 0
3 0 00 00 00 202 0
1 0 00 00 00 203 0
0 1 00 00 00 101 0
0 2 00 00 00 100 0
0 0 28 00 00 600 3
0 2 81 00 00 600 0
0 0 00 01 00 002 0
0 0 00 02 00 204 0
0 0 00 04 00 300 8
0 0 00 08 00 301 0
0 0 00 10 60 400 5
0 0 00 20 00 601 8
0 0 00 40 80 604 7
0 0 00 80 0C 605 2
0 0 00 FE 30 204 0
0 0 00 FC 30 300 4
0 0 00 F0 00 400 8
0 0 00 E0 06 601 1
0 0 00 C0 00 604 8
0 0 00 03 00 002 0

// File: files.f
rtl/shim_mgr_pkg.sv
rtl/shim_fault_encoder.sv
rtl/shim_power_sequencer.sv
rtl/shim_hw_manager.sv
verif/shim_clock_gen.sv
verif/tb_shim_hw_manager.sv

// File: verif/tb_shim_hw_manager.sv
`timescale 1ns/100ps

module tb_shim_hw_manager import shim_mgr_pkg::*; ();

  localparam int NUM_CASES  = 23;
  localparam int FIELDS     = 7;  // Words per line of the case file
  localparam int CLK_PERIOD = 40;
  localparam int DRIVE_DLY  = 2;  // Input skew after the rising edge
  localparam int DELAY_SUM  = SPI_OFF_MIN_WAIT + SPI_RESET_WAIT + SHUTDOWN_FORCE_DELAY +
                              SPI_START_WAIT + SHUTDOWN_RESET_PULSE + SHUTDOWN_RESET_DELAY;
  localparam int MARGIN     = 40; // Idle, hold and return cycles per case

  logic        clk;
  logic        aresetn;
  logic        sys_en;
  logic        spi_off;
  logic        ext_shutdown;
  logic        integ_thresh_avg_oob;
  logic        integ_window_oob;
  logic        integ_en_oob;
  logic        sys_en_oob;
  logic        lock_viol;
  board_vec_t  shutdown_sense;
  board_vec_t  over_thresh;
  board_vec_t  dac_boot_fail;
  board_vec_t  bad_dac_cmd;
  board_vec_t  dac_cmd_buf_underflow;
  board_vec_t  dac_cmd_buf_overflow;
  logic        unlock_cfg;
  logic        spi_clk_power_n;
  logic        spi_en;
  logic        shutdown_sense_en;
  logic        block_buffers;
  logic        n_shutdown_force;
  logic        n_shutdown_rst;
  logic        ps_interrupt;
  logic [31:0] status_word;

  // Status word split by field
  mgr_state_t   cur_state;
  status_code_t cur_code;
  board_idx_t   cur_board;
  logic [7:0]   ctrl; // All control outputs with unlock_cfg first

  logic [31:0] case_mem [0:NUM_CASES*FIELDS-1];
  integer      seed;
  int          errors;
  int          checks;
  int          spi_mode;      // 0 normal, 1 never off, 2 never starts
  logic        spi_en_q;      // spi_en before the last edge
  int          irq_count;
  int          rst_low_count;
  int          state_cycles [0:15]; // Samples spent in each state

  assign cur_state = mgr_state_t'(status_word[3:0]);
  assign cur_code  = status_word[28:4];
  assign cur_board = status_word[31:29];
  assign ctrl = {unlock_cfg, spi_clk_power_n, spi_en, shutdown_sense_en,
                 block_buffers, n_shutdown_force, n_shutdown_rst, ps_interrupt};

  shim_clock_gen u_clk_gen (.clk(clk), .aresetn(aresetn));

  shim_hw_manager UUT (.*);

  // SPI subsystem model goes active one clock after it sees spi_en
  always @(posedge clk) begin
    #DRIVE_DLY;
    case (spi_mode)
      1:       spi_off = 1'b0; // Never reports off
      2:       spi_off = 1'b1; // Never starts
      default: spi_off = !spi_en_q;
    endcase
    spi_en_q = spi_en;
  end

  // Hard stop if something hangs
  initial begin
    #(NUM_CASES * (DELAY_SUM + MARGIN) * CLK_PERIOD);
    $display("Watchdog expired at %0t, the cases did not finish", $time);
    $display("=== FAIL ===");
    $finish;
  end

  function automatic board_idx_t lowest_flag_index(input board_vec_t v);
    for (int i = 0; i < NUM_BOARDS; i++) begin
      if (v[i]) return board_idx_t'(i);
    end
    return '0;
  endfunction

  task automatic check_code(input string what, input status_code_t got, input status_code_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED at %0t: %s code 0x%0h, expected 0x%0h", $time, what, got, exp);
    end
  endtask

  task automatic check_board(input string what, input board_idx_t got, input board_idx_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED at %0t: %s board %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_state(input string what, input mgr_state_t got, input mgr_state_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED at %0t: %s state %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_ctrl(input string what, input logic [7:0] got, input logic [7:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED at %0t: %s controls %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_count(input string what, input int got, input int exp);
    checks++;
    if (got != exp) begin
      errors++;
      $display("FAILED at %0t: %s %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  // Advance one clock and tally what the DUT shows
  task automatic step();
    @(posedge clk);
    #DRIVE_DLY;
    state_cycles[status_word[3:0]]++;
    if (ps_interrupt) irq_count++;
    if (!n_shutdown_rst) rst_low_count++;
  endtask

  task automatic wait_state(input mgr_state_t target, input int limit);
    int n;
    n = 0;
    while (cur_state !== target && n < limit) begin
      step();
      n++;
    end
    if (cur_state !== target) begin
      errors++;
      $display("State %0d never arrived within %0d cycles, DUT sits in state %0d",
               target, limit, cur_state);
    end
  endtask

  task automatic drive_run_faults(input logic [7:0] mask, input board_vec_t vec);
    sys_en                = !mask[0];
    lock_viol             = mask[1];
    shutdown_sense        = mask[2] ? vec : '0;
    ext_shutdown          = mask[3];
    over_thresh           = mask[4] ? vec : '0;
    bad_dac_cmd           = mask[5] ? vec : '0;
    dac_cmd_buf_underflow = mask[6] ? vec : '0;
    dac_cmd_buf_overflow  = mask[7] ? vec : '0;
  endtask

  task automatic run_case(input int idx);
    logic [3:0]   cfg_mask;
    int           mode;
    board_vec_t   boot_vec;
    logic [7:0]   run_mask;
    board_vec_t   run_vec;
    status_code_t exp_code;
    board_idx_t   exp_board;
    logic         running;
    string        tag;

    tag      = $sformatf("case %0d", idx);
    cfg_mask = case_mem[idx*FIELDS][3:0];
    mode     = case_mem[idx*FIELDS+1];
    boot_vec = case_mem[idx*FIELDS+2][7:0];
    run_mask = case_mem[idx*FIELDS+3][7:0];
    run_vec  = case_mem[idx*FIELDS+4][7:0];
    exp_code = case_mem[idx*FIELDS+5][CODE_W-1:0];
    if (run_mask != 0 && run_vec == 0) begin
      run_vec = board_vec_t'($random(seed));
      if (run_vec == 0) run_vec = 8'h01;
    end
    // Board 8 in the file means lowest flag of the vector in use
    if (case_mem[idx*FIELDS+6] == 8) exp_board = lowest_flag_index(run_vec);
    else exp_board = case_mem[idx*FIELDS+6][BOARD_W-1:0];
    running = (cfg_mask == 0) && (mode == 0) && (boot_vec == 0);

    irq_count     = 0;
    rst_low_count = 0;
    foreach (state_cycles[s]) state_cycles[s] = 0;
    {integ_thresh_avg_oob, integ_window_oob, integ_en_oob, sys_en_oob} = cfg_mask;
    spi_mode      = mode;
    dac_boot_fail = boot_vec;
    repeat (2) step(); // Let the SPI model settle in the new mode
    sys_en = 1'b1;

    if (running) begin
      wait_state(S_RUNNING, DELAY_SUM + MARGIN);
      check_ctrl({tag, " running entry"}, ctrl, 8'h37);
      check_count({tag, " reset pulse cycles"}, rst_low_count, SHUTDOWN_RESET_PULSE + 1);
      check_count({tag, " ctrl board power cycles"}, state_cycles[S_POWER_ON_CTRL_BRD],
                  SHUTDOWN_FORCE_DELAY + 1);
      check_count({tag, " amp settle cycles"}, state_cycles[S_AMP_POWER_WAIT],
                  SHUTDOWN_RESET_DELAY + 1);
      drive_run_faults(run_mask, run_vec); // First cycle after entry is blind
    end

    wait_state(S_HALTED, DELAY_SUM + MARGIN);
    check_code({tag, " halt"}, cur_code, exp_code);
    check_board({tag, " halt"}, cur_board, exp_board);
    check_ctrl({tag, " halt"}, ctrl, {cfg_mask != 0, 7'b100_1011}); // Safe pattern
    if (running) begin
      // Entry sample plus the blind interrupt cycle
      check_count({tag, " running cycles"}, state_cycles[S_RUNNING], 2);
    end
    if (mode == 1) begin
      check_count({tag, " SPI reset wait cycles"}, state_cycles[S_CONFIRM_SPI_RST],
                  SPI_RESET_WAIT + 1);
    end else if (cfg_mask == 0) begin
      check_count({tag, " SPI off confirm cycles"}, state_cycles[S_CONFIRM_SPI_RST],
                  SPI_OFF_MIN_WAIT + 1);
    end
    if (mode == 2 && boot_vec == 0) begin
      check_count({tag, " SPI start wait cycles"}, state_cycles[S_CONFIRM_SPI_START],
                  SPI_START_WAIT + 1);
    end

    repeat (3) step();
    if (!(running && run_mask[0])) check_state({tag, " halt hold"}, cur_state, S_HALTED);

    // Processor drops enable and everything returns to idle
    drive_run_faults(8'h00, '0);
    {integ_thresh_avg_oob, integ_window_oob, integ_en_oob, sys_en_oob} = 4'h0;
    dac_boot_fail = '0;
    sys_en        = 1'b0;
    wait_state(S_IDLE, MARGIN);
    check_code({tag, " idle return"}, cur_code, STS_OK);
    check_board({tag, " idle return"}, cur_board, '0);
    check_ctrl({tag, " idle return"}, ctrl, 8'hCA);
    check_count({tag, " interrupt pulses"}, irq_count, running ? 2 : 1);
  endtask

  initial begin
    seed     = 32'h4d6f;
    errors   = 0;
    checks   = 0;
    spi_mode = 0;
    spi_en_q = 1'b0;
    spi_off  = 1'b1;
    sys_en   = 1'b0;
    {integ_thresh_avg_oob, integ_window_oob, integ_en_oob, sys_en_oob} = 4'h0;
    dac_boot_fail = '0;
    drive_run_faults(8'h00, '0);
    sys_en = 1'b0;

    $readmemh("verif/shim_cases.txt", case_mem);
    if ($isunknown(case_mem[NUM_CASES*FIELDS-1])) begin
      errors++;
      $display("Case file verif/shim_cases.txt is missing or has too few entries");
    end

    wait (aresetn === 1'b1);
    step();
    check_state("after reset", cur_state, S_IDLE);
    check_code("after reset", cur_code, STS_OK);
    check_board("after reset", cur_board, '0);
    check_ctrl("after reset", ctrl, 8'hCA);

    if (errors == 0) begin
      for (int i = 0; i < NUM_CASES; i++) run_case(i);
    end

    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// File: verif/shim_clock_gen.sv
`timescale 1ns/100ps

module shim_clock_gen (
  output logic clk,
  output logic aresetn
);

  localparam int PERIOD_NS    = 40;
  localparam int RESET_CYCLES = 4;

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk; // 25 MHz
  end

  // Reset released just after a rising edge, like any other input
  initial begin
    aresetn = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #2 aresetn = 1'b1;
  end

endmodule

// File: rtl/shim_hw_manager.sv
`timescale 1ns/100ps

module shim_hw_manager import shim_mgr_pkg::*; (
  input  logic        clk,
  input  logic        aresetn,
  input  logic        sys_en,       // System enable
  input  logic        spi_off,      // SPI subsystem off
  input  logic        ext_shutdown, // External shutdown request
  // Pre-start configuration
  input  logic        integ_thresh_avg_oob,
  input  logic        integ_window_oob,
  input  logic        integ_en_oob,
  input  logic        sys_en_oob,
  input  logic        lock_viol,    // Write to locked config
  // Per board flags
  input  board_vec_t  shutdown_sense,
  input  board_vec_t  over_thresh,
  input  board_vec_t  dac_boot_fail,
  input  board_vec_t  bad_dac_cmd,
  input  board_vec_t  dac_cmd_buf_underflow,
  input  board_vec_t  dac_cmd_buf_overflow,
  // Controls
  output logic        unlock_cfg,
  output logic        spi_clk_power_n,
  output logic        spi_en,
  output logic        shutdown_sense_en,
  output logic        block_buffers,
  output logic        n_shutdown_force,
  output logic        n_shutdown_rst,
  output logic        ps_interrupt,
  output logic [31:0] status_word // Board, code, state
);

  // Encoder to sequencer
  logic         cfg_fault;
  status_code_t cfg_code;
  logic         run_fault;
  status_code_t run_code;
  board_idx_t   run_board;
  logic         boot_fault;
  status_code_t boot_code;
  board_idx_t   boot_board;

  // Status fields
  mgr_state_t   state;
  status_code_t status_code;
  board_idx_t   board_num;

  shim_fault_encoder u_encoder (
    .integ_thresh_avg_oob  (integ_thresh_avg_oob),
    .integ_window_oob      (integ_window_oob),
    .integ_en_oob          (integ_en_oob),
    .sys_en_oob            (sys_en_oob),
    .lock_viol             (lock_viol),
    .sys_en                (sys_en),
    .ext_shutdown          (ext_shutdown),
    .shutdown_sense        (shutdown_sense),
    .over_thresh           (over_thresh),
    .dac_boot_fail         (dac_boot_fail),
    .bad_dac_cmd           (bad_dac_cmd),
    .dac_cmd_buf_underflow (dac_cmd_buf_underflow),
    .dac_cmd_buf_overflow  (dac_cmd_buf_overflow),
    .cfg_fault             (cfg_fault),
    .cfg_code              (cfg_code),
    .run_fault             (run_fault),
    .run_code              (run_code),
    .run_board             (run_board),
    .boot_fault            (boot_fault),
    .boot_code             (boot_code),
    .boot_board            (boot_board)
  );

  shim_power_sequencer u_sequencer (
    .clk               (clk),
    .aresetn           (aresetn),
    .sys_en            (sys_en),
    .spi_off           (spi_off),
    .cfg_fault         (cfg_fault),
    .cfg_code          (cfg_code),
    .run_fault         (run_fault),
    .run_code          (run_code),
    .run_board         (run_board),
    .boot_fault        (boot_fault),
    .boot_code         (boot_code),
    .boot_board        (boot_board),
    .unlock_cfg        (unlock_cfg),
    .spi_clk_power_n   (spi_clk_power_n),
    .spi_en            (spi_en),
    .shutdown_sense_en (shutdown_sense_en),
    .block_buffers     (block_buffers),
    .n_shutdown_force  (n_shutdown_force),
    .n_shutdown_rst    (n_shutdown_rst),
    .ps_interrupt      (ps_interrupt),
    .state             (state),
    .status_code       (status_code),
    .board_num         (board_num)
  );

  // 3 + 25 + 4 bits
  assign status_word = {board_num, status_code, state};

endmodule

// File: rtl/shim_power_sequencer.sv
`timescale 1ns/100ps

module shim_power_sequencer import shim_mgr_pkg::*; (
  input  logic         clk,
  input  logic         aresetn,
  input  logic         sys_en,  // System enable from processor
  input  logic         spi_off, // SPI subsystem reports off
  // From fault encoder
  input  logic         cfg_fault,
  input  status_code_t cfg_code,
  input  logic         run_fault,
  input  status_code_t run_code,
  input  board_idx_t   run_board,
  input  logic         boot_fault,
  input  status_code_t boot_code,
  input  board_idx_t   boot_board,
  // Power and SPI controls
  output logic         unlock_cfg,
  output logic         spi_clk_power_n,
  output logic         spi_en,
  output logic         shutdown_sense_en,
  output logic         block_buffers,
  output logic         n_shutdown_force,
  output logic         n_shutdown_rst,
  output logic         ps_interrupt,
  // Status fields
  output mgr_state_t   state,
  output status_code_t status_code,
  output board_idx_t   board_num
);

  logic [TIMER_W-1:0] timer; // Phase timer, zero on entry to each state

  logic         spi_rst_ok; // SPI confirmed off after min wait
  logic         halt_req;   // Go to HALTED this clock
  status_code_t halt_code;
  board_idx_t   halt_board;

  assign spi_rst_ok = (timer >= TIMER_W'(SPI_OFF_MIN_WAIT)) && spi_off;

  // Halt decision, one place for every state
  always_comb begin
    halt_req   = 1'b0;
    halt_code  = STS_OK;
    halt_board = '0;
    case (state)
      S_IDLE: begin
        // Config checked only at enable
        if (sys_en && cfg_fault) begin
          halt_req  = 1'b1;
          halt_code = cfg_code;
        end
      end
      S_CONFIRM_SPI_RST: begin
        if (!spi_rst_ok && timer >= TIMER_W'(SPI_RESET_WAIT)) begin
          halt_req  = 1'b1;
          halt_code = STS_SPI_RESET_TIMEOUT;
        end
      end
      S_CONFIRM_SPI_START: begin
        if (spi_off) begin // Started beats any late failure
          if (boot_fault) begin
            halt_req   = 1'b1;
            halt_code  = boot_code;
            halt_board = boot_board;
          end else if (timer >= TIMER_W'(SPI_START_WAIT)) begin
            halt_req  = 1'b1;
            halt_code = STS_SPI_START_TIMEOUT;
          end
        end
      end
      S_RUNNING: begin
        // Entry interrupt cycle is a blind cycle
        if (!ps_interrupt && run_fault) begin
          halt_req   = 1'b1;
          halt_code  = run_code;
          halt_board = run_board;
        end
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!aresetn) begin
      state             <= S_IDLE;
      timer             <= '0;
      status_code       <= STS_OK;
      board_num         <= '0;
      unlock_cfg        <= 1'b1;
      spi_clk_power_n   <= 1'b1;
      spi_en            <= 1'b0;
      shutdown_sense_en <= 1'b0;
      block_buffers     <= 1'b1;
      n_shutdown_force  <= 1'b0; // Power stage held off
      n_shutdown_rst    <= 1'b1;
      ps_interrupt      <= 1'b0;
    end else begin
      ps_interrupt <= 1'b0; // Single cycle pulse by default

      if (halt_req) begin
        // Everything to safe values, config stays as it was
        state             <= S_HALTED;
        timer             <= '0;
        status_code       <= halt_code;
        board_num         <= halt_board;
        spi_clk_power_n   <= 1'b1;
        spi_en            <= 1'b0;
        shutdown_sense_en <= 1'b0;
        block_buffers     <= 1'b1;
        n_shutdown_force  <= 1'b0;
        n_shutdown_rst    <= 1'b1;
        ps_interrupt      <= 1'b1;
      end else begin
        case (state)
          S_IDLE: begin
            if (sys_en) begin
              // Lock config, clock the SPI block to see it idle
              state           <= S_CONFIRM_SPI_RST;
              timer           <= '0;
              unlock_cfg      <= 1'b0;
              spi_clk_power_n <= 1'b0;
            end
          end

          S_CONFIRM_SPI_RST: begin
            if (spi_rst_ok) begin
              state            <= S_POWER_ON_CTRL_BRD;
              timer            <= '0;
              spi_clk_power_n  <= 1'b1;
              n_shutdown_force <= 1'b1; // Release control board
            end else begin
              timer <= timer + 1'b1;
            end
          end

          S_POWER_ON_CTRL_BRD: begin
            if (timer >= TIMER_W'(SHUTDOWN_FORCE_DELAY)) begin
              state             <= S_CONFIRM_SPI_START;
              timer             <= '0;
              shutdown_sense_en <= 1'b1;
              spi_clk_power_n   <= 1'b0;
              spi_en            <= 1'b1; // Kick off DAC boot over SPI
            end else begin
              timer <= timer + 1'b1;
            end
          end

          S_CONFIRM_SPI_START: begin
            if (!spi_off) begin
              state          <= S_POWER_ON_AMP_BRD;
              timer          <= '0;
              n_shutdown_rst <= 1'b0; // Start reset pulse
            end else begin
              timer <= timer + 1'b1;
            end
          end

          S_POWER_ON_AMP_BRD: begin
            if (timer >= TIMER_W'(SHUTDOWN_RESET_PULSE)) begin
              state          <= S_AMP_POWER_WAIT;
              timer          <= '0;
              n_shutdown_rst <= 1'b1;
            end else begin
              timer <= timer + 1'b1;
            end
          end

          S_AMP_POWER_WAIT: begin
            if (timer >= TIMER_W'(SHUTDOWN_RESET_DELAY)) begin
              state         <= S_RUNNING;
              timer         <= '0;
              block_buffers <= 1'b0; // Let commands and data flow
              ps_interrupt  <= 1'b1;
            end else begin
              timer <= timer + 1'b1;
            end
          end

          S_RUNNING: timer <= '0; // Faults handled by halt_req

          S_HALTED: begin
            // Wait for processor to drop enable
            if (!sys_en) begin
              state       <= S_IDLE;
              status_code <= STS_OK;
              board_num   <= '0;
              unlock_cfg  <= 1'b1;
            end
          end

          default: begin
            state <= S_IDLE; // Unused encodings recover
            timer <= '0;
          end
        endcase
      end
    end
  end

endmodule

// File: rtl/shim_fault_encoder.sv
`timescale 1ns/100ps

module shim_fault_encoder import shim_mgr_pkg::*; (
  // Pre-start configuration flags
  input  logic         integ_thresh_avg_oob,
  input  logic         integ_window_oob,
  input  logic         integ_en_oob,
  input  logic         sys_en_oob,
  // Running system flags
  input  logic         lock_viol,
  input  logic         sys_en,
  input  logic         ext_shutdown,
  // Per board flags
  input  board_vec_t   shutdown_sense,
  input  board_vec_t   over_thresh,
  input  board_vec_t   dac_boot_fail,
  input  board_vec_t   bad_dac_cmd,
  input  board_vec_t   dac_cmd_buf_underflow,
  input  board_vec_t   dac_cmd_buf_overflow,
  // Pre-start result
  output logic         cfg_fault,
  output status_code_t cfg_code,
  // Running result
  output logic         run_fault,
  output status_code_t run_code,
  output board_idx_t   run_board,
  // DAC boot result
  output logic         boot_fault,
  output status_code_t boot_code,
  output board_idx_t   boot_board
);

  // Pre-start checks, first match by priority
  always_comb begin
    cfg_fault = 1'b1;
    cfg_code  = STS_OK;
    if (integ_thresh_avg_oob) begin
      cfg_code = STS_INTEG_THRESH_AVG_OOB;
    end else if (integ_window_oob) begin
      cfg_code = STS_INTEG_WINDOW_OOB;
    end else if (integ_en_oob) begin
      cfg_code = STS_INTEG_EN_OOB;
    end else if (sys_en_oob) begin
      cfg_code = STS_SYS_EN_OOB;
    end else begin
      cfg_fault = 1'b0; // Config clean
    end
  end

  // Running faults, highest priority first
  always_comb begin
    run_fault = 1'b1;
    run_code  = STS_OK;
    run_board = '0; // Non-board faults report board 0
    if (!sys_en) begin
      run_code = STS_PS_SHUTDOWN; // Processor pulled enable
    end else if (lock_viol) begin
      run_code = STS_LOCK_VIOL;
    end else if (|shutdown_sense) begin
      run_code  = STS_SHUTDOWN_SENSE;
      run_board = lowest_board(shutdown_sense);
    end else if (ext_shutdown) begin
      run_code = STS_EXT_SHUTDOWN;
    end else if (|over_thresh) begin
      run_code  = STS_OVER_THRESH;
      run_board = lowest_board(over_thresh);
    end else if (|bad_dac_cmd) begin
      run_code  = STS_BAD_DAC_CMD;
      run_board = lowest_board(bad_dac_cmd);
    end else if (|dac_cmd_buf_underflow) begin
      run_code  = STS_DAC_BUF_UNDERFLOW;
      run_board = lowest_board(dac_cmd_buf_underflow);
    end else if (|dac_cmd_buf_overflow) begin
      run_code  = STS_DAC_BUF_OVERFLOW;
      run_board = lowest_board(dac_cmd_buf_overflow);
    end else begin
      run_fault = 1'b0;
    end
  end

  // DAC boot failure during SPI start
  // Only one code, board picks the lowest failing DAC
  assign boot_fault = |dac_boot_fail;
  assign boot_code  = STS_DAC_BOOT_FAIL;
  assign boot_board = lowest_board(dac_boot_fail);

endmodule

// File: rtl/shim_mgr_pkg.sv
package shim_mgr_pkg;

  // Board geometry
  localparam int NUM_BOARDS = 8; // Amplifier boards in the chassis
  localparam int BOARD_W    = 3; // Board index width

  // Status word fields
  localparam int STATE_W = 4;  // Sequencer state field
  localparam int CODE_W  = 25; // Status code field

  localparam int TIMER_W = 32; // Phase timer width

  // Phase delays in clock cycles, kept short for simulation
  localparam int unsigned SPI_OFF_MIN_WAIT     = 10; // Min wait before trusting spi_off
  localparam int unsigned SPI_RESET_WAIT       = 40; // SPI must report off by here
  localparam int unsigned SHUTDOWN_FORCE_DELAY = 20; // Control board power settle
  localparam int unsigned SPI_START_WAIT       = 60; // SPI must come up by here
  localparam int unsigned SHUTDOWN_RESET_PULSE = 5;  // n_shutdown_rst low width, minus one
  localparam int unsigned SHUTDOWN_RESET_DELAY = 20; // Amp board settle before running

  typedef logic [NUM_BOARDS-1:0] board_vec_t; // One flag per board
  typedef logic [BOARD_W-1:0]    board_idx_t; // Board index
  typedef logic [CODE_W-1:0]     status_code_t;

  // Sequencer states, zero unused
  typedef enum logic [STATE_W-1:0] {
    S_IDLE              = 4'd1,
    S_CONFIRM_SPI_RST   = 4'd2,
    S_POWER_ON_CTRL_BRD = 4'd3,
    S_CONFIRM_SPI_START = 4'd4,
    S_POWER_ON_AMP_BRD  = 4'd5,
    S_AMP_POWER_WAIT    = 4'd6,
    S_RUNNING           = 4'd7,
    S_HALTED            = 4'd8
  } mgr_state_t;

  // Basic system
  localparam status_code_t STS_OK          = 25'h000_0001;
  localparam status_code_t STS_PS_SHUTDOWN = 25'h000_0002; // Enable dropped while running

  // SPI subsystem
  localparam status_code_t STS_SPI_START_TIMEOUT = 25'h000_0100;
  localparam status_code_t STS_SPI_RESET_TIMEOUT = 25'h000_0101;

  // Pre-start configuration and lock
  localparam status_code_t STS_INTEG_THRESH_AVG_OOB = 25'h000_0200;
  localparam status_code_t STS_INTEG_WINDOW_OOB     = 25'h000_0201;
  localparam status_code_t STS_INTEG_EN_OOB         = 25'h000_0202;
  localparam status_code_t STS_SYS_EN_OOB           = 25'h000_0203;
  localparam status_code_t STS_LOCK_VIOL            = 25'h000_0204;

  // Shutdown sense
  localparam status_code_t STS_SHUTDOWN_SENSE = 25'h000_0300; // Per board
  localparam status_code_t STS_EXT_SHUTDOWN   = 25'h000_0301;

  // Integrator
  localparam status_code_t STS_OVER_THRESH = 25'h000_0400; // Per board

  // DAC, all per board
  localparam status_code_t STS_DAC_BOOT_FAIL     = 25'h000_0600;
  localparam status_code_t STS_BAD_DAC_CMD       = 25'h000_0601;
  localparam status_code_t STS_DAC_BUF_UNDERFLOW = 25'h000_0604;
  localparam status_code_t STS_DAC_BUF_OVERFLOW  = 25'h000_0605;

  // Index of the lowest set flag, zero when none set
  function automatic board_idx_t lowest_board(input board_vec_t flags);
    board_idx_t idx;
    idx = '0;
    // Walk down so the lowest set bit wins
    for (int i = NUM_BOARDS - 1; i >= 0; i--) begin
      if (flags[i]) idx = BOARD_W'(i);
    end
    return idx;
  endfunction

endpackage
